/* hw/dsp_pio_pkg.sv */
// register select enum, cpu request / config / irq source structs, strobe constants
`default_nettype none

package dsp_pio_pkg;

    // register addressed by a cpu request
    typedef enum logic [1:0] {
        PIOC = 2'd0,    // parallel control word
        PDX0 = 2'd1,    // parallel data 0
        PDX1 = 2'd2,    // parallel data 1
        SDX  = 2'd3     // serial data
    } pio_reg_e;

    // cpu side access, one cycle strobes
    typedef struct packed {
        logic        load;  // long immediate load
        logic        read;  // register read
        pio_reg_e    sel;
        logic [15:0] imm;
    } cpu_req_t;

    // control word bits 14..5, same order as the register
    typedef struct packed {
        logic [1:0] stlen;      // strobe length minus one
        logic       po_mode;    // active output strobe
        logic       pi_mode;    // active input strobe
        logic       scmode;     // upper byte of pbus_out don't care when set
        logic [4:0] ien;        // interrupt enables
    } pio_cfg_t;

    // interrupt source levels
    typedef struct packed {
        logic ext_irq;
        logic sio_full;
        logic sio_empty;
    } irq_src_t;

    // both modes active, no enables
    localparam logic [9:0] PIOC_RESET = 10'b00_1_1_0_00000;

    // strobe start pattern, shifted left by stlen
    localparam logic [3:0] STROBE_SEED = 4'b1110;

    // enable bit positions inside ien
    localparam int IEN_IRQ = 0;
    localparam int IEN_SRD = 3;     // serial read buffer full
    localparam int IEN_SWR = 4;     // serial write buffer empty

endpackage

`default_nettype wire

/* hw/pio_port.sv */
// parallel port: control word, strobe counters, capture registers, bus output, read mux
`timescale 1ns/1ps
`default_nettype none

module pio_port (
    input  wire                    rst,
    input  wire                    clk,
    input  wire                    cen,
    input  wire dsp_pio_pkg::cpu_req_t req,
    input  wire             [15:0] pbus_in,
    output logic            [15:0] pbus_out,
    output logic                   pods_n,     // output data strobe
    output logic                   pids_n,     // input data strobe
    output logic                   psel,       // peripheral select
    input  wire             [ 4:0] status,     // sio flags and gated irq
    output dsp_pio_pkg::pio_cfg_t  cfg,
    output logic            [15:0] dout
);

    dsp_pio_pkg::pio_cfg_t pioc;   // bit 15 mirrors bit 4 on reads

    logic [3:0]  pocnt;            // output strobe shifter, bit 0 is the strobe
    logic [3:0]  picnt;            // input strobe shifter
    logic [3:0]  ststart;
    logic [15:0] pdx0_rd;
    logic [15:0] pdx1_rd;

    logic pdx_sel;
    logic pdx_load;
    logic pdx_read;
    logic pioc_load;
    logic capture;

    assign cfg = pioc;

    // low bits set the strobe width, stlen+1 zeros
    assign ststart = dsp_pio_pkg::STROBE_SEED << pioc.stlen;

    assign pdx_sel   = (req.sel == dsp_pio_pkg::PDX0) || (req.sel == dsp_pio_pkg::PDX1);
    assign pdx_load  = req.load & pdx_sel;
    assign pdx_read  = req.read & pdx_sel;
    assign pioc_load = req.load & (req.sel == dsp_pio_pkg::PIOC);

    assign pods_n = pocnt[0];
    assign pids_n = picnt[0];

    // last low cycle of the input strobe
    assign capture = ~picnt[0] & picnt[1];

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pocnt <= 4'hf;
            picnt <= 4'hf;
            psel  <= 1'b0;
            pioc  <= dsp_pio_pkg::PIOC_RESET;
        end else if (cen) begin
            // a new access restarts the strobe, otherwise shift ones in
            pocnt <= pdx_load ? ststart : {1'b1, pocnt[3:1]};
            picnt <= pdx_read ? ststart : {1'b1, picnt[3:1]};

            if (pdx_load || pdx_read) begin
                psel <= (req.sel == dsp_pio_pkg::PDX1);
            end

            if (pioc_load) begin
                pioc <= req.imm[14:5];  // bit 15 and status bits are read only
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (cen) begin
            if (capture) begin
                if (psel) begin
                    pdx1_rd <= pbus_in;
                end else begin
                    pdx0_rd <= pbus_in;
                end
            end

            if (pdx_load) begin
                pbus_out <= req.imm;    // held until the next load
            end
        end
    end

    // read mux
    always_comb begin
        case (req.sel)
            dsp_pio_pkg::PIOC: dout = {status[4], pioc, status};
            dsp_pio_pkg::PDX1: dout = pdx1_rd;
            default:           dout = pdx0_rd;  // sdx is taken from the serial unit
        endcase
    end

endmodule

`default_nettype wire

/* hw/pio_irq.sv */
// interrupt logic: source and iack edge detection, enable gating, one cycle latch
`timescale 1ns/1ps
`default_nettype none

module pio_irq (
    input  wire                    rst,
    input  wire                    clk,
    input  wire dsp_pio_pkg::irq_src_t src,
    input  wire                    iack,
    input  wire dsp_pio_pkg::pio_cfg_t cfg,
    output logic                   irq_latch,
    output logic                   irq_status  // ext irq and its enable
);

    logic last_irq;
    logic last_full;
    logic last_empty;
    logic last_iack;

    logic iack_fall;
    logic irq_rise;
    logic full_rise;
    logic empty_rise;
    logic req_any;

    assign iack_fall  = ~iack & last_iack;
    assign irq_rise   = src.ext_irq & ~last_irq;
    assign full_rise  = src.sio_full & ~last_full;
    assign empty_rise = src.sio_empty & ~last_empty;

    // enabled or of the edges
    assign req_any = (irq_rise   & cfg.ien[dsp_pio_pkg::IEN_IRQ]) |
                     (full_rise  & cfg.ien[dsp_pio_pkg::IEN_SRD]) |
                     (empty_rise & cfg.ien[dsp_pio_pkg::IEN_SWR]);

    assign irq_status = src.ext_irq & cfg.ien[dsp_pio_pkg::IEN_IRQ];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_irq   <= 1'b0;
            last_full  <= 1'b0;
            last_empty <= 1'b0;
            last_iack  <= 1'b0;
            irq_latch  <= 1'b0;
        end else begin
            last_iack  <= iack;
            // acknowledge forgets the level so a held irq can fire again
            last_irq   <= src.ext_irq & ~iack_fall;
            last_full  <= src.sio_full;
            last_empty <= src.sio_empty;
            irq_latch  <= req_any & ~iack_fall;     // single cycle request
        end
    end

endmodule

`default_nettype wire

/* hw/sio_unit.sv */
// serial unit: receive shifter and buffer with full flag, transmit shifter with empty flag
`timescale 1ns/1ps
`default_nettype none

module sio_unit (
    input  wire                    rst,
    input  wire                    clk,
    input  wire dsp_pio_pkg::cpu_req_t req,
    input  wire                    sio_in,
    input  wire                    sio_in_stb,    // one bit per strobe
    input  wire                    sio_out_stb,
    output logic                   sio_out,
    output logic                   sio_full,      // read buffer holds a word
    output logic                   sio_empty,     // write buffer drained
    output logic            [15:0] dout
);

    logic [15:0] rx_sr;        // receive shifter, first bit ends up as msb
    logic [15:0] rx_buf;
    logic [3:0]  rx_cnt;       // bits received so far
    logic        rx_done;

    logic [15:0] tx_sr;
    logic [3:0]  tx_left;      // bits left after the current one

    logic sdx_load;
    logic sdx_read;

    assign sdx_load = req.load & (req.sel == dsp_pio_pkg::SDX);
    assign sdx_read = req.read & (req.sel == dsp_pio_pkg::SDX);

    assign rx_done = sio_in_stb & (rx_cnt == 4'd15);

    assign dout    = rx_buf;
    assign sio_out = tx_sr[15] & ~sio_empty;  // line idles low

    // receive control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_cnt   <= 4'd0;
            sio_full <= 1'b0;
        end else begin
            if (sio_in_stb) begin
                rx_cnt <= rx_cnt + 4'd1;   // wraps after 16 bits
            end
            if (rx_done) begin
                sio_full <= 1'b1;          // new word wins over a read
            end else if (sdx_read) begin
                sio_full <= 1'b0;
            end
        end
    end

    // receive data
    always_ff @(posedge clk) begin
        if (sio_in_stb) begin
            rx_sr <= {rx_sr[14:0], sio_in};
        end
        if (rx_done) begin
            rx_buf <= {rx_sr[14:0], sio_in};
        end
    end

    // transmit control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_left   <= 4'd0;
            sio_empty <= 1'b1;
        end else if (sdx_load) begin
            tx_left   <= 4'd15;
            sio_empty <= 1'b0;
        end else if (sio_out_stb && !sio_empty) begin
            tx_left <= tx_left - 4'd1;
            if (tx_left == 4'd0) begin
                sio_empty <= 1'b1;          // 16th bit gone
            end
        end
    end

    // transmit data, msb first
    always_ff @(posedge clk) begin
        if (sdx_load) begin
            tx_sr <= req.imm;
        end else if (sio_out_stb && !sio_empty) begin
            tx_sr <= {tx_sr[14:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* hw/dsp_pio_top.sv */
// top level: parallel port, serial unit, interrupt block, status and read data mux
`timescale 1ns/1ps
`default_nettype none

module dsp_pio_top (
    input  wire                    rst,
    input  wire                    clk,
    input  wire                    cen,
    input  wire dsp_pio_pkg::cpu_req_t req,
    input  wire             [15:0] pbus_in,
    input  wire                    irq,
    input  wire                    iack,
    input  wire                    sio_in,
    input  wire                    sio_in_stb,
    input  wire                    sio_out_stb,
    output logic            [15:0] dout,
    output logic            [15:0] pbus_out,
    output logic                   pods_n,
    output logic                   pids_n,
    output logic                   psel,
    output logic                   sio_out,
    output logic                   irq_latch
);

    dsp_pio_pkg::pio_cfg_t cfg;
    dsp_pio_pkg::irq_src_t src;

    logic [15:0] pio_dout;
    logic [15:0] sio_dout;
    logic [4:0]  status;
    logic        sio_full;
    logic        sio_empty;
    logic        irq_status;

    assign src.ext_irq   = irq;
    assign src.sio_full  = sio_full;
    assign src.sio_empty = sio_empty;

    // status field of the control word read
    assign status = {sio_empty, sio_full, 2'b00, irq_status};

    assign dout = (req.sel == dsp_pio_pkg::SDX) ? sio_dout : pio_dout;

    pio_port u_port (
        .rst      (rst),
        .clk      (clk),
        .cen      (cen),
        .req      (req),
        .pbus_in  (pbus_in),
        .pbus_out (pbus_out),
        .pods_n   (pods_n),
        .pids_n   (pids_n),
        .psel     (psel),
        .status   (status),
        .cfg      (cfg),
        .dout     (pio_dout)
    );

    sio_unit u_sio (
        .rst         (rst),
        .clk         (clk),
        .req         (req),
        .sio_in      (sio_in),
        .sio_in_stb  (sio_in_stb),
        .sio_out_stb (sio_out_stb),
        .sio_out     (sio_out),
        .sio_full    (sio_full),
        .sio_empty   (sio_empty),
        .dout        (sio_dout)
    );

    // runs every clk, no cen
    pio_irq u_irq (
        .rst        (rst),
        .clk        (clk),
        .src        (src),
        .iack       (iack),
        .cfg        (cfg),
        .irq_latch  (irq_latch),
        .irq_status (irq_status)
    );

endmodule

`default_nettype wire

/* testbench/pio_checker.sv */
// checker comparing dut outputs with the expected columns of the stimulus file
`timescale 1ns/1ps
`default_nettype none

module pio_checker (
    input  wire                    clk,
    input  wire                    active,
    input  wire             [71:0] expect_vec,
    input  wire                    cen,
    input  wire dsp_pio_pkg::cpu_req_t req,
    input  wire             [15:0] dout,
    input  wire             [15:0] pbus_out,
    input  wire                    pods_n,
    input  wire                    pids_n,
    input  wire                    psel,
    input  wire                    irq_latch,
    input  wire                    sio_out,
    output int                     errors,
    output int                     checks
);

    logic [15:0] exp_dout;
    logic [15:0] dout_mask;
    logic [15:0] exp_pbus;
    logic [15:0] pbus_mask;
    logic [3:0]  exp_bits;     // pods_n, pids_n, irq_latch, sio_out
    logic [3:0]  bit_mask;
    logic        exp_psel;     // low after reset

    assign exp_dout  = expect_vec[71:56];
    assign dout_mask = expect_vec[55:40];
    assign exp_pbus  = expect_vec[39:24];
    assign pbus_mask = expect_vec[23:8];
    assign exp_bits  = expect_vec[7:4];
    assign bit_mask  = expect_vec[3:0];

    initial begin
        errors   = 0;
        checks   = 0;
        exp_psel = 1'b0;
    end

    // masked compare where a zero mask means don't care
    task automatic compare(input string name, input logic [15:0] exp,
                           input logic [15:0] act, input logic [15:0] mask);
        if (mask != 16'h0) begin
            checks++;
            if ((act & mask) !== (exp & mask)) begin
                errors++;
                $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            end
        end
    endtask

    // outputs settled since the falling edge and flops not yet updated
    always @(posedge clk) begin
        if (active) begin
            compare("dout", exp_dout, dout, dout_mask);
            compare("pbus_out", exp_pbus, pbus_out, pbus_mask);
            compare("pods_n", {15'd0, exp_bits[3]}, {15'd0, pods_n}, {15'd0, bit_mask[3]});
            compare("pids_n", {15'd0, exp_bits[2]}, {15'd0, pids_n}, {15'd0, bit_mask[2]});
            compare("irq_latch", {15'd0, exp_bits[1]}, {15'd0, irq_latch},
                    {15'd0, bit_mask[1]});
            compare("sio_out", {15'd0, exp_bits[0]}, {15'd0, sio_out}, {15'd0, bit_mask[0]});
            compare("psel", {15'd0, exp_psel}, {15'd0, psel}, 16'h0001);

            // pdx access picks the data register from the next cen edge on
            if (cen && (req.load || req.read) &&
                (req.sel == dsp_pio_pkg::PDX0 || req.sel == dsp_pio_pkg::PDX1)) begin
                exp_psel = (req.sel == dsp_pio_pkg::PDX1);
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/pio_assert.sv */
// concurrent assertions on strobe length and interrupt pulse width, bound into the top
`timescale 1ns/1ps
`default_nettype none

module pio_assert (
    input wire       clk,
    input wire       rst,
    input wire       pods_n,
    input wire       pids_n,
    input wire       irq_latch,
    input wire [1:0] stlen
);

    // no strobe ends before stlen+1 cycles, restarts only make it longer
    a_pods_len: assert property (@(posedge clk) disable iff (rst)
        $rose(pods_n) |-> (stlen < 2'd1 || !$past(pods_n, 2)) &&
                          (stlen < 2'd2 || !$past(pods_n, 3)) &&
                          (stlen < 2'd3 || !$past(pods_n, 4)))
        else $error("pods_n strobe shorter than stlen+1 cycles");

    a_pids_len: assert property (@(posedge clk) disable iff (rst)
        $rose(pids_n) |-> (stlen < 2'd1 || !$past(pids_n, 2)) &&
                          (stlen < 2'd2 || !$past(pids_n, 3)) &&
                          (stlen < 2'd3 || !$past(pids_n, 4)))
        else $error("pids_n strobe shorter than stlen+1 cycles");

    // request is a single cycle pulse
    a_irq_pulse: assert property (@(posedge clk) disable iff (rst)
        irq_latch |=> !irq_latch)
        else $error("irq_latch high for more than one cycle");

endmodule

bind dsp_pio_top pio_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .pods_n    (pods_n),
    .pids_n    (pids_n),
    .irq_latch (irq_latch),
    .stlen     (cfg.stlen)
);

`default_nettype wire

/* testbench/tb_dsp_pio.sv */
// testbench top with clock, reset, file driven stimulus, timeout and final report
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_pio;

    logic                  clk;
    logic                  rst;
    logic                  cen;
    dsp_pio_pkg::cpu_req_t req;
    logic [15:0]           pbus_in;
    logic                  irq;
    logic                  iack;
    logic                  sio_in;
    logic                  sio_in_stb;
    logic                  sio_out_stb;

    logic [15:0] dout;
    logic [15:0] pbus_out;
    logic        pods_n;
    logic        pids_n;
    logic        psel;
    logic        sio_out;
    logic        irq_latch;

    logic [71:0]  expect_vec;   // expected values and masks of the current line
    logic         active;       // checker enabled
    int           line_cnt;
    int           cycles;
    int           errors;
    int           checks;
    logic [115:0] stim_mem [0:255];

    dsp_pio_top dut0 (
        .rst         (rst),
        .clk         (clk),
        .cen         (cen),
        .req         (req),
        .pbus_in     (pbus_in),
        .irq         (irq),
        .iack        (iack),
        .sio_in      (sio_in),
        .sio_in_stb  (sio_in_stb),
        .sio_out_stb (sio_out_stb),
        .dout        (dout),
        .pbus_out    (pbus_out),
        .pods_n      (pods_n),
        .pids_n      (pids_n),
        .psel        (psel),
        .sio_out     (sio_out),
        .irq_latch   (irq_latch)
    );

    pio_checker u_chk (
        .clk        (clk),
        .active     (active),
        .expect_vec (expect_vec),
        .cen        (cen),
        .req        (req),
        .dout       (dout),
        .pbus_out   (pbus_out),
        .pods_n     (pods_n),
        .pids_n     (pids_n),
        .psel       (psel),
        .irq_latch  (irq_latch),
        .sio_out    (sio_out),
        .errors     (errors),
        .checks     (checks)
    );

    always #50 clk = ~clk;  // 100 ns period

    // split one stimulus word onto the dut inputs
    task automatic apply_line(input logic [115:0] v);
        req         = dsp_pio_pkg::cpu_req_t'(v[115:96]);  // load, read, sel, imm
        pbus_in     = v[95:80];
        cen         = v[79];
        irq         = v[78];
        iack        = v[77];
        sio_in      = v[76];
        sio_in_stb  = v[75];
        sio_out_stb = v[74];
        expect_vec  = v[71:0];
    endtask

    // entries still holding their address marker were not in the file
    function automatic int count_lines();
        int n;
        n = 0;
        while (n < 256 && stim_mem[n] != ~116'(n))
            n++;
        return n;
    endfunction

    // cycle limit from the number of lines
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > line_cnt + 50) begin
            $display("timeout: run did not end within %0d cycles", line_cnt + 50);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        active = 1'b0;
        cycles = 0;
        apply_line('0);
        for (int i = 0; i < 256; i++) begin
            stim_mem[i] = ~116'(i);     // marker built from the address
        end
        $readmemh("testbench/pio_stimulus.txt", stim_mem);
        line_cnt = count_lines();

        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < line_cnt; i++) begin
            apply_line(stim_mem[i]);    // applied on the falling edge and checked on the next rise
            active = 1'b1;
            @(negedge clk);
        end
        active = 1'b0;

        if (line_cnt == 0) begin
            $display("no stimulus lines could be read from the data file");
        end
        $display("lines %0d, checks %0d, errors %0d", line_cnt, checks, errors);
        if (errors == 0 && line_cnt > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/pio_stimulus.txt */
// {load,read,sel}_imm_pbusin_{cen,irq,iack,sioin}{instb,outstb,0,0}_expdout_mask_exppbus_mask_
// {pods_n,pids_n,irq_latch,sio_out} expected then mask; mask bits of 0 are don't care
8_9b3f_0000_80_9810_ffff_0000_0000_cf
4_0000_0000_80_9b30_ffff_0000_0000_cf
9_a5c3_0000_80_0000_0000_0000_0000_cf
0_0000_0000_80_0000_0000_a5c3_ffff_4f
0_0000_0000_80_0000_0000_a5c3_ffff_cf
8_7b20_0000_80_0000_0000_a5c3_ffff_cf
9_1234_0000_80_0000_0000_a5c3_ffff_cf
0_0000_0000_80_0000_0000_1234_ffff_4f
0_0000_0000_80_0000_0000_1234_ffff_4f
0_0000_0000_80_0000_0000_1234_ffff_4f
0_0000_0000_80_0000_0000_1234_ffff_4f
6_0000_1111_80_0000_0000_1234_ffff_cf
0_0000_1111_80_0000_0000_1234_ffff_8f
0_0000_2222_80_0000_0000_1234_ffff_8f
0_0000_3333_80_0000_0000_1234_ffff_8f
0_0000_beef_80_0000_0000_1234_ffff_8f
6_0000_0000_80_beef_ffff_1234_ffff_cf
5_0000_0000_80_0000_0000_1234_ffff_8f
0_0000_0000_80_0000_0000_1234_ffff_8f
0_0000_0000_80_0000_0000_1234_ffff_8f
0_0000_0000_80_0000_0000_1234_ffff_8f
0_0000_cafe_80_0000_0000_1234_ffff_8f
5_0000_0000_80_cafe_ffff_1234_ffff_cf
0_0000_0000_c0_0000_0000_1234_ffff_8f
4_0000_0000_c0_fb31_ffff_1234_ffff_af
0_0000_0000_a0_0000_0000_1234_ffff_8f
0_0000_0000_c0_0000_0000_1234_ffff_8f
0_0000_0000_c0_0000_0000_1234_ffff_cf
0_0000_0000_c0_0000_0000_1234_ffff_ef
8_1b00_0000_80_0000_0000_1234_ffff_cf
0_0000_0000_c0_0000_0000_1234_ffff_cf
0_0000_0000_80_0000_0000_1234_ffff_cf
b_a35c_0000_80_0000_0000_1234_ffff_cf
0_0000_0000_84_0000_0000_1234_ffff_df
0_0000_0000_84_0000_0000_1234_ffff_cf
0_0000_0000_8c_0000_0000_1234_ffff_df
0_0000_0000_9c_0000_0000_1234_ffff_cf
0_0000_0000_8c_0000_0000_1234_ffff_cf
0_0000_0000_9c_0000_0000_1234_ffff_cf
0_0000_0000_9c_0000_0000_1234_ffff_df
0_0000_0000_8c_0000_0000_1234_ffff_df
0_0000_0000_9c_0000_0000_1234_ffff_cf
0_0000_0000_8c_0000_0000_1234_ffff_df
0_0000_0000_9c_0000_0000_1234_ffff_cf
0_0000_0000_8c_0000_0000_1234_ffff_df
0_0000_0000_8c_0000_0000_1234_ffff_df
0_0000_0000_9c_0000_0000_1234_ffff_df
0_0000_0000_8c_0000_0000_1234_ffff_cf
0_0000_0000_9c_0000_0000_1234_ffff_cf
0_0000_0000_98_0000_0000_1234_ffff_cf
0_0000_0000_88_0000_0000_1234_ffff_ef
0_0000_0000_80_0000_0000_1234_ffff_cf
7_0000_0000_80_5a96_ffff_1234_ffff_ef
4_0000_0000_80_9b10_ffff_1234_ffff_cf

/* vlog.f */
hw/dsp_pio_pkg.sv
hw/pio_port.sv
hw/pio_irq.sv
hw/sio_unit.sv
hw/dsp_pio_top.sv
testbench/pio_checker.sv
testbench/pio_assert.sv
testbench/tb_dsp_pio.sv

/* Makefile */
# Verilator build and run for the dsp parallel / serial io block

VERILATOR ?= verilator
TOP       ?= tb_dsp_pio
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# status comes from the pass message in the simulator output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
